//--- Makefile
TOP = tb_compute_tile

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
logic/tile_pkg.sv
logic/wb_bus_decode.sv
logic/wb_sram_sp.sv
logic/bootrom.sv
logic/na_mp_send.sv
logic/na_flit_fifo.sv
logic/na_noc_out.sv
logic/compute_tile.sv
tb/tb_compute_tile.sv

//--- logic/bootrom.sv
`timescale 1ns/1ns

module bootrom (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               stb_i,
   input  tile_pkg::word_t    adr_i,
   output logic               ack_o,
   output tile_pkg::word_t    dat_o
);

   logic              ack_q;
   tile_pkg::word_t   dat_q;
   tile_pkg::word_t   entry;                         // Table lookup

   // Boot stub, clears r1 and jumps to 0x100
   always_comb begin
      case (adr_i[4:2])                              // Word adr modulo 8
         3'd0:    entry = 32'h1800_0000;             // l.movhi r0,0
         3'd1:    entry = 32'ha820_0000;             // l.ori r1,r0,0
         3'd2:    entry = 32'h1860_0000;             // l.movhi r3,0
         3'd3:    entry = 32'ha863_0100;             // l.ori r3,r3,0x100
         3'd4:    entry = 32'h4400_1800;             // l.jr r3
         3'd5:    entry = 32'h1500_0000;             // Delay slot nop
         3'd6:    entry = 32'h1500_0001;
         default: entry = 32'h1500_0002;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (stb_i && !ack_q)
         dat_q <= entry;                             // Writes read too, data dropped
   end

   always_ff @(posedge clk_i) begin
      if (reset_i)
         ack_q <= 1'b0;
      else
         ack_q <= stb_i & ~ack_q;
   end

   assign ack_o = ack_q;
   assign dat_o = dat_q;

endmodule

//--- logic/compute_tile.sv
`timescale 1ns/1ns

module compute_tile #(
   parameter int MEM_WORDS  = 256,                  // Local RAM size in words
   parameter int FIFO_DEPTH = 4                     // Flit queue depth, power of two
) (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                bus_cyc_i,            // External bus master
   input  logic                bus_stb_i,
   input  logic                bus_we_i,
   input  tile_pkg::word_t     bus_adr_i,
   input  tile_pkg::sel_t      bus_sel_i,
   input  tile_pkg::word_t     bus_dat_i,
   output logic                bus_ack_o,
   output logic                bus_err_o,
   output tile_pkg::word_t     bus_dat_o,
   output tile_pkg::flit_t     noc_out_flit_o,       // NoC output channel
   output logic                noc_out_valid_o,
   input  logic                noc_out_ready_i
);

   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);    // Occupancy incl. full

   logic               ram_stb, ram_ack;             // RAM slave
   tile_pkg::word_t    ram_dat;
   logic               na_stb, na_ack;               // Adapter slave
   tile_pkg::word_t    na_dat;
   logic               rom_stb, rom_ack;             // Boot ROM slave
   tile_pkg::word_t    rom_dat;

   logic               fifo_push, fifo_pop;          // Send chain
   tile_pkg::flit_t    push_flit, head_flit;
   logic               fifo_empty, fifo_full;
   logic [CNT_W-1:0]   fifo_count;

   wb_bus_decode u_bus (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .m_cyc_i   (bus_cyc_i),
      .m_stb_i   (bus_stb_i),
      .m_adr_i   (bus_adr_i),
      .m_ack_o   (bus_ack_o),
      .m_err_o   (bus_err_o),
      .m_dat_o   (bus_dat_o),
      .ram_stb_o (ram_stb),
      .ram_ack_i (ram_ack),
      .ram_dat_i (ram_dat),
      .na_stb_o  (na_stb),
      .na_ack_i  (na_ack),
      .na_dat_i  (na_dat),
      .rom_stb_o (rom_stb),
      .rom_ack_i (rom_ack),
      .rom_dat_i (rom_dat)
   );

   wb_sram_sp #(.MEM_WORDS(MEM_WORDS)) u_ram (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .stb_i   (ram_stb),
      .we_i    (bus_we_i),
      .adr_i   (bus_adr_i),
      .sel_i   (bus_sel_i),
      .dat_i   (bus_dat_i),
      .ack_o   (ram_ack),
      .dat_o   (ram_dat)
   );

   bootrom u_bootrom (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .stb_i   (rom_stb),
      .adr_i   (bus_adr_i),
      .ack_o   (rom_ack),
      .dat_o   (rom_dat)
   );

   na_mp_send #(.FIFO_DEPTH(FIFO_DEPTH)) u_mp_send (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .stb_i        (na_stb),
      .we_i         (bus_we_i),
      .adr_i        (bus_adr_i),
      .dat_i        (bus_dat_i),
      .ack_o        (na_ack),
      .dat_o        (na_dat),
      .fifo_full_i  (fifo_full),
      .fifo_count_i (fifo_count),
      .push_o       (fifo_push),
      .flit_o       (push_flit)
   );

   na_flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_flit_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (fifo_push),
      .flit_i  (push_flit),
      .pop_i   (fifo_pop),
      .head_o  (head_flit),
      .empty_o (fifo_empty),
      .full_o  (fifo_full),
      .count_o (fifo_count)
   );

   na_noc_out u_noc_out (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .head_i          (head_flit),
      .empty_i         (fifo_empty),
      .pop_o           (fifo_pop),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i)
   );

endmodule

//--- logic/na_flit_fifo.sv
`timescale 1ns/1ns

module na_flit_fifo #(
   parameter int FIFO_DEPTH = 4                      // Power of two
) (
   input  logic                                 clk_i,
   input  logic                                 reset_i,
   input  logic                                 push_i,
   input  tile_pkg::flit_t                      flit_i,
   input  logic                                 pop_i,
   output tile_pkg::flit_t                      head_o,
   output logic                                 empty_o,
   output logic                                 full_o,
   output logic [$clog2(FIFO_DEPTH+1)-1:0]      count_o
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   tile_pkg::flit_t   mem [FIFO_DEPTH];              // Flit storage
   logic [PTR_W-1:0]  wr_ptr, rd_ptr;                // Wrap by overflow
   logic [CNT_W-1:0]  count;

   always_ff @(posedge clk_i) begin
      if (push_i)
         mem[wr_ptr] <= flit_i;
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                 // Both or neither
         endcase
      end
   end

   assign head_o  = mem[rd_ptr];                     // Valid when not empty
   assign empty_o = (count == '0);
   assign full_o  = (count == CNT_W'(FIFO_DEPTH));
   assign count_o = count;

   assert property (@(posedge clk_i) disable iff (reset_i) !(pop_i && empty_o));

endmodule

//--- logic/na_mp_send.sv
`timescale 1ns/1ns

module na_mp_send #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                 clk_i,
   input  logic                                 reset_i,
   input  logic                                 stb_i,
   input  logic                                 we_i,
   input  tile_pkg::word_t                      adr_i,
   input  tile_pkg::word_t                      dat_i,
   output logic                                 ack_o,
   output tile_pkg::word_t                      dat_o,
   input  logic                                 fifo_full_i,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0]      fifo_count_i,
   output logic                                 push_o,
   output tile_pkg::flit_t                      flit_o
);

   logic [1:0]             offset;                   // Word offset in window
   logic                   data_wr;                  // Write that makes a flit
   logic                   ack_q;
   tile_pkg::word_t        dat_q;
   tile_pkg::flit_type_t   ftype;
   tile_pkg::flit_data_t   payload;

   assign offset  = adr_i[3:2];
   assign data_wr = we_i & (offset != 2'd3);
   assign payload = dat_i;

   always_comb begin
      case (offset)
         2'd0:    ftype = tile_pkg::HEADER;
         2'd2:    ftype = tile_pkg::LAST;
         default: ftype = tile_pkg::PAYLOAD;         // Offset 1
      endcase
   end

   assign flit_o = {ftype, payload};
   assign push_o = stb_i & data_wr & ~fifo_full_i & ~ack_q;  // Stall while full

   always_ff @(posedge clk_i) begin
      if (reset_i)
         ack_q <= 1'b0;
      else
         ack_q <= push_o | (stb_i & ~data_wr & ~ack_q);   // Push or register access
   end

   always_ff @(posedge clk_i) begin
      if (stb_i && !ack_q) begin
         if (!we_i && offset == 2'd3)
            dat_q <= tile_pkg::word_t'(FIFO_DEPTH) - tile_pkg::word_t'(fifo_count_i);
         else
            dat_q <= '0;                             // Data regs read as zero
      end
   end

   assign ack_o = ack_q;
   assign dat_o = dat_q;

   // A stalled write keeps its request up until acked
   assert property (@(posedge clk_i) disable iff (reset_i) (stb_i && !ack_o) |=> stb_i);

endmodule

//--- logic/na_noc_out.sv
`timescale 1ns/1ns

module na_noc_out (
   input  logic               clk_i,
   input  logic               reset_i,
   input  tile_pkg::flit_t    head_i,                // FIFO head
   input  logic               empty_i,
   output logic               pop_o,
   output tile_pkg::flit_t    noc_out_flit_o,        // To the router
   output logic               noc_out_valid_o,
   input  logic               noc_out_ready_i
);

   logic              valid_q;
   tile_pkg::flit_t   flit_q;
   logic              load;                          // Take next head

   assign load  = ~empty_i & (~valid_q | noc_out_ready_i);   // Empty or draining
   assign pop_o = load;

   always_ff @(posedge clk_i) begin
      if (reset_i)
         valid_q <= 1'b0;
      else if (load)
         valid_q <= 1'b1;
      else if (noc_out_ready_i)
         valid_q <= 1'b0;                            // Sent with nothing behind it
   end

   always_ff @(posedge clk_i) begin
      if (load)
         flit_q <= head_i;
   end

   assign noc_out_flit_o  = flit_q;
   assign noc_out_valid_o = valid_q;

   // Queued head holds until popped
   assert property (@(posedge clk_i) disable iff (reset_i)
      (!empty_i && !pop_o) |=> $stable(head_i));

endmodule

//--- logic/tile_pkg.sv
package tile_pkg;

   localparam int WORD_W      = 32;                 // Bus address and data width
   localparam int SEL_W       = WORD_W / 8;         // One select bit per byte lane
   localparam int FLIT_TYPE_W = 2;
   localparam int FLIT_DATA_W = 32;
   localparam int FLIT_W      = FLIT_TYPE_W + FLIT_DATA_W;

   typedef logic [WORD_W-1:0]      word_t;          // Bus address or data word
   typedef logic [SEL_W-1:0]       sel_t;           // Byte select
   typedef logic [FLIT_DATA_W-1:0] flit_data_t;     // Flit payload
   typedef logic [FLIT_W-1:0]      flit_t;          // Type on top, payload below

   // Flit kinds as used on the NoC link
   typedef enum logic [FLIT_TYPE_W-1:0] {
      PAYLOAD = 2'b00,
      HEADER  = 2'b01,
      LAST    = 2'b10,
      SINGLE  = 2'b11                               // Never sent by this tile
   } flit_type_t;

   // Targets of the on-tile bus decoder
   typedef enum logic [1:0] {
      SLV_RAM,
      SLV_NA,
      SLV_ROM,
      SLV_NONE                                      // Unmapped, answered with err
   } slave_t;

   localparam logic [3:0] NA_WINDOW  = 4'he;        // Top nibble of adapter window
   localparam logic [3:0] ROM_WINDOW = 4'hf;        // Top nibble of boot ROM window

endpackage

//--- logic/wb_bus_decode.sv
`timescale 1ns/1ns

module wb_bus_decode (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               m_cyc_i,               // Master request
   input  logic               m_stb_i,
   input  tile_pkg::word_t    m_adr_i,
   output logic               m_ack_o,               // Master response
   output logic               m_err_o,
   output tile_pkg::word_t    m_dat_o,
   output logic               ram_stb_o,             // Per slave strobes
   input  logic               ram_ack_i,
   input  tile_pkg::word_t    ram_dat_i,
   output logic               na_stb_o,
   input  logic               na_ack_i,
   input  tile_pkg::word_t    na_dat_i,
   output logic               rom_stb_o,
   input  logic               rom_ack_i,
   input  tile_pkg::word_t    rom_dat_i
);

   tile_pkg::slave_t  slv;                           // Selected target
   logic              req;                           // Valid strobe in a cycle
   logic              err_q;                         // Registered err for holes

   assign req = m_cyc_i & m_stb_i;

   // Address windows, RAM is the whole lower half
   always_comb begin
      if (!m_adr_i[31])
         slv = tile_pkg::SLV_RAM;
      else if (m_adr_i[31:28] == tile_pkg::NA_WINDOW)
         slv = tile_pkg::SLV_NA;
      else if (m_adr_i[31:28] == tile_pkg::ROM_WINDOW)
         slv = tile_pkg::SLV_ROM;
      else
         slv = tile_pkg::SLV_NONE;                   // 8 through D
   end

   assign ram_stb_o = req & (slv == tile_pkg::SLV_RAM);
   assign na_stb_o  = req & (slv == tile_pkg::SLV_NA);
   assign rom_stb_o = req & (slv == tile_pkg::SLV_ROM);

   always_comb begin
      case (slv)                                     // Response mux, adr held
         tile_pkg::SLV_RAM: begin
            m_ack_o = ram_ack_i;
            m_dat_o = ram_dat_i;
         end
         tile_pkg::SLV_NA: begin
            m_ack_o = na_ack_i;
            m_dat_o = na_dat_i;
         end
         tile_pkg::SLV_ROM: begin
            m_ack_o = rom_ack_i;
            m_dat_o = rom_dat_i;
         end
         default: begin
            m_ack_o = 1'b0;                          // Err path only
            m_dat_o = '0;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i)
         err_q <= 1'b0;
      else
         err_q <= req & (slv == tile_pkg::SLV_NONE) & ~err_q;  // One cycle
   end

   assign m_err_o = err_q;

   // Slave acks and local err must never collide on the master
   assert property (@(posedge clk_i) disable iff (reset_i) !(m_ack_o && m_err_o));

endmodule

//--- logic/wb_sram_sp.sv
`timescale 1ns/1ns

module wb_sram_sp #(
   parameter int MEM_WORDS = 256                     // Power of two
) (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               stb_i,
   input  logic               we_i,
   input  tile_pkg::word_t    adr_i,
   input  tile_pkg::sel_t     sel_i,
   input  tile_pkg::word_t    dat_i,
   output logic               ack_o,
   output tile_pkg::word_t    dat_o
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   tile_pkg::word_t   mem [MEM_WORDS];               // Word storage
   logic [IDX_W-1:0]  idx;                           // Word index modulo MEM_WORDS
   logic              ack_q;
   tile_pkg::word_t   dat_q;

   assign idx = adr_i[IDX_W+1:2];                    // Byte adr to word modulo

   always_ff @(posedge clk_i) begin
      if (stb_i && we_i && !ack_q) begin             // Write once per access
         for (int b = 0; b < tile_pkg::SEL_W; b++) begin
            if (sel_i[b])
               mem[idx][8*b +: 8] <= dat_i[8*b +: 8];   // Selected lanes only
         end
      end
      if (stb_i && !ack_q)
         dat_q <= mem[idx];                          // Old word on a write
   end

   always_ff @(posedge clk_i) begin
      if (reset_i)
         ack_q <= 1'b0;
      else
         ack_q <= stb_i & ~ack_q;                    // Drops while stb held
   end

   assign ack_o = ack_q;
   assign dat_o = dat_q;

   // Master holds stb through the ack cycle
   assert property (@(posedge clk_i) disable iff (reset_i) ack_o |-> stb_i);

endmodule

//--- tb/compute_tile_stim.txt
# op addr data sel exp, all hex; W write, R read expecting data, E access expecting err (exp 1 = write)
# X expected flit (addr = type, data = payload), H hold NoC ready low, S write blocked by full queue, D drain
# RAM with full and partial byte selects
W 00000010 11223344 f 0
R 00000010 0 f 11223344
W 00000010 aabbccdd 5 0
R 00000010 0 f 11bb33dd
W 00000014 cafef00d f 0
W 00000014 00005500 2 0
R 00000014 0 f cafe550d
W 00000400 12345678 f 0
R 00000000 0 f 12345678
W 00000018 a5a5a5a5 f 0
W 00000018 00000000 8 0
R 00000018 0 f 00a5a5a5
# Boot ROM, word address modulo 8
R f0000000 0 f 18000000
R f000000c 0 f a8630100
R f0000024 0 f a8200000
R f000001c 0 f 15000002
W f0000004 deadbeef f 0
R f0000004 0 f a8200000
# Unmapped windows, RAM word 4 must stay intact
E 80000010 55555555 f 1
E 9000001c 0 f 0
E d0000010 ffffffff f 1
R 00000010 0 f 11bb33dd
# Header, payload, last in write order
X 1 00000101 0 0
W e0000000 00000101 f 0
X 0 00000202 0 0
W e0000004 00000202 f 0
X 2 00000303 0 0
W e0000008 00000303 f 0
R e0000000 0 f 0
W e000000c 99999999 f 0
D 0 0 0 0
# Back-pressure, five flits fill output register and queue
H 0 0 0 0
X 1 00000010 0 0
W e0000000 00000010 f 0
X 0 00000011 0 0
W e0000004 00000011 f 0
X 0 00000012 0 0
W e0000004 00000012 f 0
X 0 00000013 0 0
W e0000004 00000013 f 0
X 0 00000014 0 0
W e0000004 00000014 f 0
R e000000c 0 f 0
X 2 00000015 0 0
S e0000008 00000015 f 0
D 0 0 0 0
R e000000c 0 f 4

//--- tb/tb_compute_tile.sv
`timescale 1ns/1ns

module tb_compute_tile;

   localparam int CLK_PERIOD  = 10;
   localparam int FIFO_DEPTH  = 4;                   // Matches the DUT default
   localparam int RESP_LIMIT  = 100;                 // Cycles to wait for ack or err
   localparam int STALL_CHECK = 20;                  // Cycles a blocked write must wait
   localparam int DRAIN_LIMIT = 500;

   logic               clk;
   logic               reset;
   logic               bus_cyc, bus_stb, bus_we;     // Master side
   tile_pkg::word_t    bus_adr, bus_wdat, bus_rdat;
   tile_pkg::sel_t     bus_sel;
   logic               bus_ack, bus_err;
   tile_pkg::flit_t    noc_flit;                     // NoC side
   logic               noc_valid;
   logic               noc_ready = 1'b0;
   logic               ready_hold = 1'b0;            // Forces ready low

   int                 seed = 32'h699e;
   int                 rnd;
   bit                 stim_loaded = 1'b0;

   logic [7:0]         op_q[$];                      // Stim columns
   tile_pkg::word_t    adr_q[$], dat_q[$], sel_q[$], exp_q[$];
   tile_pkg::flit_t    exp_flits[$];                 // Filled by X lines
   int                 flit_rd_idx = 0;              // Next expected flit index

   int                 value_errors = 0;
   int                 flit_errors = 0;
   int                 other_fails = 0;

   compute_tile #(.MEM_WORDS(256), .FIFO_DEPTH(FIFO_DEPTH)) compute_tile_i (
      .clk_i           (clk),
      .reset_i         (reset),
      .bus_cyc_i       (bus_cyc),
      .bus_stb_i       (bus_stb),
      .bus_we_i        (bus_we),
      .bus_adr_i       (bus_adr),
      .bus_sel_i       (bus_sel),
      .bus_dat_i       (bus_wdat),
      .bus_ack_o       (bus_ack),
      .bus_err_o       (bus_err),
      .bus_dat_o       (bus_rdat),
      .noc_out_flit_o  (noc_flit),
      .noc_out_valid_o (noc_valid),
      .noc_out_ready_i (noc_ready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   always @(posedge clk) begin                       // Random back-pressure
      rnd = $random(seed);
      noc_ready <= ready_hold ? 1'b0 : rnd[0];
   end

   task automatic check_word(input tile_pkg::word_t got, input tile_pkg::word_t exp,
                             input string what);
      if (got !== exp) begin
         value_errors++;
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_err(input logic got, input logic exp, input tile_pkg::word_t adr);
      if (got !== exp) begin
         value_errors++;
         $display("ERR %0t: err at %h was %b expected %b", $time, adr, got, exp);
      end
   endtask

   task automatic check_flit(input tile_pkg::flit_t got, input tile_pkg::flit_t exp);
      if (got !== exp) begin
         flit_errors++;
         $display("ERR %0t: flit %0d got type %0d data %h expected type %0d data %h",
                  $time, flit_rd_idx, got[33:32], got[31:0], exp[33:32], exp[31:0]);
      end
   endtask

   // Taken at the next rising edge when both are high here
   always @(negedge clk) begin
      if (!reset && noc_valid && noc_ready) begin
         if (flit_rd_idx >= exp_flits.size()) begin
            flit_errors++;
            $display("Flit %h left the tile with no flit expected", noc_flit);
         end else begin
            check_flit(noc_flit, exp_flits[flit_rd_idx]);
         end
         flit_rd_idx++;
      end
   end

   task automatic load_stim(output bit ok);
      int               fd;
      int               c;
      int               n;
      logic [7:0]       ch;
      tile_pkg::word_t  a, d, s, e;
      ok = 1'b0;
      fd = $fopen("tb/compute_tile_stim.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file tb/compute_tile_stim.txt");
      end else begin
         ok = 1'b1;
         c = $fgetc(fd);
         while (c != -1) begin
            ch = c[7:0];
            if (ch == "#") begin                     // Skip comment to end of line
               while (c != -1 && c[7:0] != "\n")
                  c = $fgetc(fd);
            end else if (ch >= "A" && ch <= "Z") begin
               n = $fscanf(fd, "%h %h %h %h", a, d, s, e);
               if (n != 4) begin
                  ok = 1'b0;
                  $display("Stimulus line for operation %c has missing columns", ch);
               end
               op_q.push_back(ch);
               adr_q.push_back(a);
               dat_q.push_back(d);
               sel_q.push_back(s);
               exp_q.push_back(e);
            end
            c = $fgetc(fd);
         end
         $fclose(fd);
      end
   endtask

   task automatic start_access(input logic we, input tile_pkg::word_t adr,
                               input tile_pkg::word_t dat, input tile_pkg::word_t sel);
      @(posedge clk);
      bus_cyc  <= 1'b1;
      bus_stb  <= 1'b1;
      bus_we   <= we;
      bus_adr  <= adr;
      bus_wdat <= dat;
      bus_sel  <= sel[3:0];
   endtask

   task automatic end_access();
      @(posedge clk);
      bus_cyc <= 1'b0;                               // Stb low at least one cycle
      bus_stb <= 1'b0;
      bus_we  <= 1'b0;
   endtask

   task automatic wait_response(output logic got_ack, output logic got_err,
                                output tile_pkg::word_t got_dat);
      int n;
      got_ack = 1'b0;
      got_err = 1'b0;
      got_dat = '0;
      n = 0;
      while (!got_ack && !got_err && n < RESP_LIMIT) begin
         @(negedge clk);                             // Outputs settled mid cycle
         got_ack = bus_ack;
         got_err = bus_err;
         got_dat = bus_rdat;
         n++;
      end
      if (!got_ack && !got_err) begin
         other_fails++;
         $display("No ack or err from the bus within %0d cycles at %0t", RESP_LIMIT, $time);
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (flit_rd_idx < exp_flits.size() && n < DRAIN_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (flit_rd_idx < exp_flits.size()) begin
         other_fails++;
         $display("%0d expected flits never left the tile", exp_flits.size() - flit_rd_idx);
      end
   endtask

   // Write that must hang on a full queue until ready comes back
   task automatic stalled_write(input int i);
      logic             ack, err;
      tile_pkg::word_t  rdat;
      int               n;
      ack = 1'b0;
      err = 1'b0;
      n = 0;
      start_access(1'b1, adr_q[i], dat_q[i], sel_q[i]);
      while (!ack && !err && n < STALL_CHECK) begin
         @(negedge clk);
         ack = bus_ack;
         err = bus_err;
         n++;
      end
      if (ack || err) begin
         other_fails++;
         $display("Adapter write at %h was answered while the flit queue was full", adr_q[i]);
      end else begin
         @(posedge clk);
         ready_hold <= 1'b0;                         // Let the queue drain
         wait_response(ack, err, rdat);
         check_err(err, 1'b0, adr_q[i]);
      end
      end_access();
   endtask

   task automatic run_op(input int i);
      logic             ack, err;
      tile_pkg::word_t  rdat;
      case (op_q[i])
         "W": begin
            start_access(1'b1, adr_q[i], dat_q[i], sel_q[i]);
            wait_response(ack, err, rdat);
            end_access();
            check_err(err, 1'b0, adr_q[i]);
         end
         "R": begin
            start_access(1'b0, adr_q[i], dat_q[i], sel_q[i]);
            wait_response(ack, err, rdat);
            end_access();
            check_err(err, 1'b0, adr_q[i]);
            if (ack)
               check_word(rdat, exp_q[i], $sformatf("read at %h", adr_q[i]));
         end
         "E": begin
            start_access(exp_q[i][0], adr_q[i], dat_q[i], sel_q[i]);   // Exp column is we
            wait_response(ack, err, rdat);
            end_access();
            check_err(err, 1'b1, adr_q[i]);
            if (ack) begin
               other_fails++;
               $display("Unmapped access at %h was acked", adr_q[i]);
            end
         end
         "X": exp_flits.push_back({adr_q[i][1:0], dat_q[i]});
         "H": begin
            @(posedge clk);
            ready_hold <= 1'b1;
            repeat (2) @(posedge clk);               // Ready low from here on
         end
         "S": stalled_write(i);
         "D": wait_drain();
         default: begin
            other_fails++;
            $display("Unknown stimulus operation %c", op_q[i]);
         end
      endcase
   endtask

   initial begin
      wait (stim_loaded);
      repeat (op_q.size() * 200) @(posedge clk);
      $display("Run stopped by the watchdog after %0d cycles", op_q.size() * 200);
      $display("Checks failed");
      $finish;
   end

   initial begin
      bit ok;
      reset    = 1'b1;
      bus_cyc  = 1'b0;
      bus_stb  = 1'b0;
      bus_we   = 1'b0;
      bus_adr  = '0;
      bus_wdat = '0;
      bus_sel  = '0;
      load_stim(ok);
      if (!ok) begin
         $display("Stimulus could not be loaded, no test was run");
         $display("Checks failed");
         $finish;
      end else begin
         stim_loaded = 1'b1;
         repeat (10) @(posedge clk);
         reset <= 1'b0;
         @(posedge clk);
         for (int i = 0; i < op_q.size(); i++)
            run_op(i);
         wait_drain();                               // Catch leftover flits
         @(negedge clk);
         $display("Errors: %0d value, %0d flit, %0d other",
                  value_errors, flit_errors, other_fails);
         if (value_errors == 0 && flit_errors == 0 && other_fails == 0)
            $display("All checks passed");
         else
            $display("Checks failed");
         $finish;
      end
   end

endmodule
